//--- rtl/rv_pkg.sv
/*
  rv32i core package
  Register and instruction word types, opcode and funct constants,
  and the ALU operation and writeback select encodings that the
  decoder, datapath and execute blocks share.
*/
package rv_pkg;

  // register width, fixed by the ISA
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;

  // major opcodes
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_auipc   = 7'b00_101_11;
  localparam opcode_t op_jal     = 7'b11_011_11;
  localparam opcode_t op_jalr    = 7'b11_001_11;
  localparam opcode_t op_branch  = 7'b11_000_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_environ = 7'b11_100_11;

  // legal funct7 values; alt picks sub and arithmetic shift right
  localparam logic [6:0] funct7_base = 7'b000_0000;
  localparam logic [6:0] funct7_alt  = 7'b010_0000;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    // lui result is the immediate itself
    alu_pass_b = 4'd10
  } alu_op_t;

  // writeback source
  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_link = 2'd1
  } wb_sel_t;

endpackage

//--- rtl/rv_regfile.sv
/*
  rv32i register file
  31 writable registers plus a hard-wired zero for x0.
  Two combinational read ports, one write port that lands on the
  rising clock edge.
*/
`timescale 1ns/10ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data
);

  // no storage behind x0
  rv_pkg::word_t regs [1:31];

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- rtl/rv_alu.sv
/*
  rv32i ALU
  Add, subtract, signed and unsigned set-less-than, logic ops,
  shifts by the low five bits of b, and a pass of b for lui.
*/
`timescale 1ns/10ps

module rv_alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   y
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:    y = a + b;
      alu_sub:    y = a - b;
      alu_sll:    y = a << shamt;
      alu_slt:    y = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   y = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:    y = a ^ b;
      alu_srl:    y = a >> shamt;
      // sign bit fills from the left
      alu_sra:    y = word_t'($signed(a) >>> shamt);
      alu_or:     y = a | b;
      alu_and:    y = a & b;
      alu_pass_b: y = b;
      default:    y = '0;
    endcase
  end

endmodule

//--- rtl/rv_decoder.sv
/*
  rv32i instruction decoder
  Splits the instruction word into register indices, builds the
  sign-extended immediate for the opcode's format and derives the
  ALU operation, operand selects, writeback control, control-flow
  flags, halt and the illegal-instruction flag.
*/
`timescale 1ns/10ps

module rv_decoder (
  input  rv_pkg::word_t     insn,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_t   alu_op,
  output logic              a_is_pc,
  output logic              b_is_imm,
  output logic              reg_we,
  output rv_pkg::wb_sel_t   wb_sel,
  output logic              branch,
  output logic              jal,
  output logic              jalr,
  output logic              halt,
  output logic              illegal
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  // funct3 to ALU op, alt selects sub / sra
  function automatic alu_op_t alu_func(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_func = alt ? alu_sub : alu_add;
      3'b001:  alu_func = alu_sll;
      3'b010:  alu_func = alu_slt;
      3'b011:  alu_func = alu_sltu;
      3'b100:  alu_func = alu_xor;
      3'b101:  alu_func = alt ? alu_sra : alu_srl;
      3'b110:  alu_func = alu_or;
      default: alu_func = alu_and;
    endcase
  endfunction

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  // immediate formats, all sign-extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    imm      = imm_i;
    alu_op   = alu_add;
    a_is_pc  = 1'b0;
    b_is_imm = 1'b0;
    reg_we   = 1'b0;
    wb_sel   = wb_alu;
    branch   = 1'b0;
    jal      = 1'b0;
    jalr     = 1'b0;
    halt     = 1'b0;
    illegal  = 1'b0;
    case (opcode)
      op_lui: begin
        imm      = imm_u;
        alu_op   = alu_pass_b;
        b_is_imm = 1'b1;
        reg_we   = 1'b1;
      end
      op_auipc: begin
        imm      = imm_u;
        a_is_pc  = 1'b1;
        b_is_imm = 1'b1;
        reg_we   = 1'b1;
      end
      op_jal: begin
        imm    = imm_j;
        jal    = 1'b1;
        wb_sel = wb_link;
        reg_we = 1'b1;
      end
      op_jalr: begin
        if (funct3 == 3'b000) begin
          jalr   = 1'b1;
          wb_sel = wb_link;
          reg_we = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      op_branch: begin
        imm = imm_b;
        // funct3 010 and 011 are reserved
        if (funct3[2:1] == 2'b01) begin
          illegal = 1'b1;
        end else begin
          branch = 1'b1;
        end
      end
      op_reg_imm: begin
        b_is_imm = 1'b1;
        reg_we   = 1'b1;
        alu_op   = alu_func(funct3, funct3 == 3'b101 && funct7 == funct7_alt);
        // only the shifts carry a funct7 field
        if (funct3 == 3'b001 && funct7 != funct7_base) begin
          illegal = 1'b1;
        end
        if (funct3 == 3'b101 && funct7 != funct7_base && funct7 != funct7_alt) begin
          illegal = 1'b1;
        end
      end
      op_reg_reg: begin
        reg_we = 1'b1;
        alu_op = alu_func(funct3, funct7 == funct7_alt);
        if (!(funct7 == funct7_base ||
              (funct7 == funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
          illegal = 1'b1;
        end
      end
      op_environ: begin
        // ecall only, every other field must be zero
        if (insn[31:7] == 25'd0) begin
          halt = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
    if (illegal) begin
      reg_we = 1'b0;
    end
  end

endmodule

//--- rtl/rv_branch_unit.sv
/*
  rv32i branch unit
  Evaluates the six branch conditions and picks the next PC:
  sequential, taken branch or jal, jalr, or hold while halted.
*/
`timescale 1ns/10ps

module rv_branch_unit (
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  input  logic [2:0]    funct3,
  input  logic          branch,
  input  logic          jal,
  input  logic          jalr,
  input  logic          halt,
  output rv_pkg::word_t next_pc,
  output logic          taken
);
  import rv_pkg::*;

  word_t seq_pc;
  word_t rel_target;
  word_t jalr_target;
  logic  cond;

  assign seq_pc      = pc + 32'd4;
  assign rel_target  = pc + imm;
  // target bit 0 is always dropped
  assign jalr_target = (rs1_data + imm) & ~32'd1;

  always_comb begin
    case (funct3)
      3'b000:  cond = rs1_data == rs2_data;
      3'b001:  cond = rs1_data != rs2_data;
      3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  cond = rs1_data < rs2_data;
      3'b111:  cond = rs1_data >= rs2_data;
      default: cond = 1'b0;
    endcase
  end

  assign taken = branch && cond;

  always_comb begin
    if (halt) begin
      next_pc = pc;
    end else if (jalr) begin
      next_pc = jalr_target;
    end else if (jal || taken) begin
      next_pc = rel_target;
    end else begin
      next_pc = seq_pc;
    end
  end

endmodule

//--- rtl/rv_core.sv
/*
  rv32i single-cycle core
  Fetches, decodes, executes and writes back one instruction per
  clock. Holds the PC, selects ALU operands and writeback data and
  drives the retirement trace. The PC stays put while halted.
*/
`timescale 1ns/10ps

module rv_core #(
  parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic              clk,
  input  logic              rst,
  output rv_pkg::word_t     pc,
  input  rv_pkg::word_t     insn,
  output logic              wb_en,
  output rv_pkg::reg_addr_t wb_rd,
  output rv_pkg::word_t     wb_data,
  output logic              halt,
  output logic              illegal
);
  import rv_pkg::*;

  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      imm;
  alu_op_t    alu_op;
  logic       a_is_pc;
  logic       b_is_imm;
  logic       reg_we;
  wb_sel_t    wb_sel;
  logic       branch;
  logic       jal;
  logic       jalr;
  logic [2:0] funct3;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_y;
  word_t      pc_plus4;
  word_t      next_pc;
  logic       taken;

  rv_decoder i_decoder (
    .insn     (insn),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .imm      (imm),
    .alu_op   (alu_op),
    .a_is_pc  (a_is_pc),
    .b_is_imm (b_is_imm),
    .reg_we   (reg_we),
    .wb_sel   (wb_sel),
    .branch   (branch),
    .jal      (jal),
    .jalr     (jalr),
    .halt     (halt),
    .illegal  (illegal)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_en),
    .rd       (wb_rd),
    .rd_data  (wb_data)
  );

  // operand a is the pc only for auipc
  assign alu_a = a_is_pc ? pc : rs1_data;
  assign alu_b = b_is_imm ? imm : rs2_data;

  rv_alu i_alu (
    .op (alu_op),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y)
  );

  assign funct3 = insn[14:12];

  rv_branch_unit i_branch_unit (
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .funct3   (funct3),
    .branch   (branch),
    .jal      (jal),
    .jalr     (jalr),
    .halt     (halt),
    .next_pc  (next_pc),
    .taken    (taken)
  );

  // writeback and retirement trace
  assign pc_plus4 = pc + 32'd4;
  assign wb_en    = reg_we;
  assign wb_rd    = rd;
  assign wb_data  = (wb_sel == wb_link) ? pc_plus4 : alu_y;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

//--- tb/rv_core_asserts.sv
/*
  rv_core assertion checker
  Concurrent checks on fetch alignment, the retirement trace, the
  halt hold and branch resolution. Bound into rv_core.
*/
`timescale 1ns/10ps

module rv_core_asserts (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t pc,
  input rv_pkg::word_t insn,
  input logic          wb_en,
  input logic          halt,
  input logic          illegal,
  input logic          taken
);
  import rv_pkg::*;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc %h is not word aligned", pc);

  a_illegal_no_wb: assert property (@(posedge clk) disable iff (rst) illegal |-> !wb_en)
    else $error("illegal instruction at pc %h writes a register", pc);

  // the pc register takes next_pc, which equals pc while halted
  a_halt_holds_pc: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else $error("pc moved after halt");

  // opcode taken straight from the fetched word
  a_taken_is_branch: assert property (@(posedge clk) disable iff (rst)
                                      taken |-> insn[6:0] == op_branch)
    else $error("taken raised for a non-branch at pc %h", pc);

endmodule

bind rv_core rv_core_asserts i_asserts (
  .clk     (clk),
  .rst     (rst),
  .pc      (pc),
  .insn    (insn),
  .wb_en   (wb_en),
  .halt    (halt),
  .illegal (illegal),
  .taken   (taken)
);

//--- tb/rv_core_tb.sv
/*
  rv_core testbench
  Runs a short RV32I program from an instruction table and compares
  the retirement trace each cycle against a table of expected pc,
  writeback, halt and illegal values.
*/
`timescale 1ns/10ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int clk_period      = 100;
  localparam int drive_delay     = 5;
  localparam int sample_delay    = 80;
  localparam int watchdog_margin = 12;

  // one retired instruction as the ISA says it should look
  typedef struct packed {
    logic [2:0] grp;
    word_t      pc;
    logic       wb_en;
    reg_addr_t  rd;
    word_t      data;
    logic       halt;
    logic       illegal;
  } step_t;

  logic      clk = 1'b0;
  logic      rst;
  word_t     pc;
  word_t     insn;
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      halt;
  logic      illegal;

  word_t imem [0:63];
  step_t steps [$];
  string grp_name [0:5] = '{"reset", "reg-imm", "reg-reg", "control flow", "x0",
                            "illegal and halt"};
  int    cur_step;
  int    n_checks;
  int    n_errors;
  int    grp_checks;
  int    grp_errors;

  rv_core #(.reset_pc(32'h0000_0000)) i_rv_core (.*);

  always #(clk_period / 2) clk = ~clk;

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #drive_delay;
    rst = 1'b0;
  end

  // instruction fetch from the table, shortly after each edge
  initial begin
    insn = '0;
    forever begin
      @(posedge clk);
      #drive_delay;
      insn = (pc < 32'd256) ? imem[pc[7:2]] : fill_word(pc);
    end
  end

  // instruction encoders by format
  function automatic word_t r_type(input int f7, rs2, rs1, f3, rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg_reg};
  endfunction

  function automatic word_t i_type(input int imm, rs1, f3, rd, input opcode_t op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic word_t b_type(input int imm, rs2, rs1, f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t u_type(input int imm, rd, input opcode_t op);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic word_t j_type(input int imm, rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
  endfunction

  // opcode 7f is unassigned, so a stray fetch shows up as illegal
  function automatic word_t fill_word(input word_t addr);
    return {addr[31:7] ^ addr[24:0], 7'h7f};
  endfunction

  task automatic check(input string what, input word_t got, input word_t exp);
    grp_checks++;
    n_checks++;
    if (got !== exp) begin
      grp_errors++;
      n_errors++;
      $display("MISMATCH at %0d ns: step %0d %s is %h, expected %h",
               $time, cur_step, what, got, exp);
    end
  endtask

  task automatic report_group(input logic [2:0] grp);
    $display("test %-16s %0d checks, %0d errors", grp_name[grp], grp_checks, grp_errors);
    grp_checks = 0;
    grp_errors = 0;
  endtask

  task automatic add_step(input int grp, addr, input word_t word,
                          input int en, rd, data, hlt, ill);
    step_t s;
    imem[addr[7:2]] = word;
    s = '{3'(grp), addr, en != 0, 5'(rd), data, hlt != 0, ill != 0};
    steps.push_back(s);
  endtask

  task automatic load_program();
    for (int i = 0; i < 64; i++) begin
      imem[i[5:0]] = fill_word(i * 4);
    end
    add_step(0, 'h00, u_type('h12345, 1, op_lui), 1, 1, 'h12345000, 0, 0);
    add_step(1, 'h04, u_type('h1, 2, op_auipc), 1, 2, 'h00001004, 0, 0);
    add_step(1, 'h08, i_type(-5, 0, 0, 3, op_reg_imm), 1, 3, 'hfffffffb, 0, 0);
    add_step(1, 'h0c, i_type(-4, 3, 2, 4, op_reg_imm), 1, 4, 'h00000001, 0, 0);
    add_step(1, 'h10, i_type(5, 3, 3, 5, op_reg_imm), 1, 5, 'h00000000, 0, 0);
    add_step(1, 'h14, i_type('hff, 1, 4, 6, op_reg_imm), 1, 6, 'h123450ff, 0, 0);
    add_step(1, 'h18, i_type('hf0, 2, 6, 7, op_reg_imm), 1, 7, 'h000010f4, 0, 0);
    add_step(1, 'h1c, i_type('hf0, 6, 7, 8, op_reg_imm), 1, 8, 'h000000f0, 0, 0);
    add_step(1, 'h20, i_type(4, 8, 1, 9, op_reg_imm), 1, 9, 'h00000f00, 0, 0);
    add_step(1, 'h24, i_type(28, 3, 5, 10, op_reg_imm), 1, 10, 'h0000000f, 0, 0);
    add_step(1, 'h28, i_type('h401, 3, 5, 11, op_reg_imm), 1, 11, 'hfffffffd, 0, 0);
    // register-register ops on the values written above
    add_step(2, 'h2c, r_type(0, 2, 1, 0, 12), 1, 12, 'h12346004, 0, 0);
    add_step(2, 'h30, r_type(32, 1, 2, 0, 13), 1, 13, 'hedcbc004, 0, 0);
    add_step(2, 'h34, r_type(0, 10, 10, 1, 14), 1, 14, 'h00078000, 0, 0);
    add_step(2, 'h38, r_type(0, 4, 3, 2, 15), 1, 15, 'h00000001, 0, 0);
    add_step(2, 'h3c, r_type(0, 4, 3, 3, 16), 1, 16, 'h00000000, 0, 0);
    add_step(2, 'h40, r_type(0, 6, 1, 4, 17), 1, 17, 'h000000ff, 0, 0);
    add_step(2, 'h44, r_type(0, 4, 3, 5, 18), 1, 18, 'h7ffffffd, 0, 0);
    add_step(2, 'h48, r_type(32, 4, 3, 5, 19), 1, 19, 'hfffffffd, 0, 0);
    add_step(2, 'h4c, r_type(0, 9, 8, 6, 20), 1, 20, 'h00000ff0, 0, 0);
    add_step(2, 'h50, r_type(0, 6, 3, 7, 21), 1, 21, 'h123450fb, 0, 0);
    // x3 = -5, x4 = 1, x5 = 0, x15 = 1; taken branches skip one slot
    add_step(3, 'h54, b_type(8, 5, 4, 0), 0, 0, 0, 0, 0);
    add_step(3, 'h58, b_type(8, 15, 4, 0), 0, 0, 0, 0, 0);
    add_step(3, 'h60, b_type(8, 15, 4, 1), 0, 0, 0, 0, 0);
    add_step(3, 'h64, b_type(8, 5, 4, 1), 0, 0, 0, 0, 0);
    add_step(3, 'h6c, b_type(8, 3, 4, 4), 0, 0, 0, 0, 0);
    add_step(3, 'h70, b_type(8, 4, 3, 4), 0, 0, 0, 0, 0);
    add_step(3, 'h78, b_type(8, 4, 3, 5), 0, 0, 0, 0, 0);
    add_step(3, 'h7c, b_type(8, 3, 4, 5), 0, 0, 0, 0, 0);
    add_step(3, 'h84, b_type(8, 4, 3, 6), 0, 0, 0, 0, 0);
    add_step(3, 'h88, b_type(8, 3, 4, 6), 0, 0, 0, 0, 0);
    add_step(3, 'h90, b_type(8, 3, 4, 7), 0, 0, 0, 0, 0);
    add_step(3, 'h94, b_type(8, 4, 3, 7), 0, 0, 0, 0, 0);
    add_step(3, 'h9c, j_type(8, 23), 1, 23, 'h000000a0, 0, 0);
    // a0 + 0x11 lands on b1, bit 0 dropped
    add_step(3, 'ha4, i_type('h11, 23, 0, 24, op_jalr), 1, 24, 'h000000a8, 0, 0);
    add_step(4, 'hb0, i_type(7, 4, 0, 0, op_reg_imm), 1, 0, 'h00000008, 0, 0);
    add_step(4, 'hb4, r_type(0, 9, 0, 0, 25), 1, 25, 'h00000f00, 0, 0);
    // funct7 01 belongs to the M extension, not implemented here
    add_step(5, 'hb8, r_type(1, 2, 1, 0, 26), 0, 0, 0, 0, 1);
    repeat (4) begin
      add_step(5, 'hbc, 'h00000073, 0, 0, 0, 1, 0);
    end
  endtask

  initial begin
    step_t s;
    load_program();
    @(posedge clk);
    for (int i = 0; i < steps.size(); i++) begin
      @(posedge clk);
      #sample_delay;
      s        = steps[i];
      cur_step = i;
      check("pc", pc, s.pc);
      check("wb_en", 32'(wb_en), 32'(s.wb_en));
      // rd and data only mean something when a register is written
      if (s.wb_en) begin
        check("wb_rd", 32'(wb_rd), 32'(s.rd));
        check("wb_data", wb_data, s.data);
      end
      check("halt", 32'(halt), 32'(s.halt));
      check("illegal", 32'(illegal), 32'(s.illegal));
      if (i == steps.size() - 1 || steps[i + 1].grp != s.grp) begin
        report_group(s.grp);
      end
    end
    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // table length plus reset and some slack
  initial begin
    #1;
    #((steps.size() + 2 + watchdog_margin) * clk_period);
    $display("timeout: the step table did not finish within its cycle limit");
    $display("Checks failed");
    $finish;
  end

endmodule

//--- filelist.f
rtl/rv_pkg.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_decoder.sv
rtl/rv_branch_unit.sv
rtl/rv_core.sv
tb/rv_core_asserts.sv
tb/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
sim_bin=rv_core_sim
log_file=sim.log

verilator --binary --timing --assert \
  --top-module rv_core_tb \
  -Mdir "$obj_dir" -o "$sim_bin" \
  -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$obj_dir/$sim_bin" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Checks failed" "$log_file"; then
  echo "simulation reported failures, see $log_file"
  exit 1
fi

echo "simulation finished clean"
exit 0
